//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = order_book_tb
FILELIST  = order_book.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/order_book_pkg.sv
/* order book shared definitions
   sizes, op and status codes, and the order, command and quote words */
package order_book_pkg;

    localparam int NUM_STOCKS = 4;
    // resting orders per stock per side
    localparam int BOOK_DEPTH = 8;
    localparam int STOCK_W = 2;
    // wide enough to hold a full count of BOOK_DEPTH
    localparam int SLOT_W = 4;
    localparam int PRICE_W = 32;
    localparam int QTY_W = 16;
    localparam int ID_W = 32;

    typedef enum logic [1:0] {
        ADD = 2'd0,
        CANCEL = 2'd1,
        // reserved, answered with a bad op status
        EXECUTE = 2'd2
    } order_op_e;

    typedef enum logic {
        BID = 1'b0,
        ASK = 1'b1
    } side_e;

    typedef enum logic [1:0] {
        ST_OK,
        ST_FULL,
        ST_NOT_FOUND,
        ST_BAD_OP
    } book_status_e;

    // incoming order message
    typedef struct packed {
        order_op_e op;
        side_e side;
        logic [STOCK_W-1:0] stock;
        logic [QTY_W-1:0] quantity;
        logic [PRICE_W-1:0] price;
        logic [ID_W-1:0] order_id;
    } order_msg_t;

    // one resting order
    typedef struct packed {
        logic [QTY_W-1:0] quantity;
        logic [PRICE_W-1:0] price;
        logic [ID_W-1:0] order_id;
    } book_entry_t;

    typedef struct packed {
        order_op_e op;
        logic [STOCK_W-1:0] stock;
        book_entry_t entry;
    } book_cmd_t;

    typedef struct packed {
        logic has_best;
        logic [PRICE_W-1:0] price;
    } side_best_t;

    typedef struct packed {
        logic [STOCK_W-1:0] stock;
        book_status_e status;
        side_best_t bid;
        side_best_t ask;
        logic crossed;
    } quote_t;

endpackage

//--- order_book.f
common/order_book_pkg.sv
order_book/order_dispatch.sv
order_book/price_level_book.sv
order_book/quote_merge.sv
order_book/order_book.sv
sim/order_book_tb.sv

//--- order_book/order_book.sv
/* multi-stock limit order book
   dispatcher, bid and ask side books and quote merger */
`timescale 1ns/1ps

module order_book import order_book_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_order_valid,
    input  order_msg_t i_order,
    output logic       o_busy,
    output logic       o_quote_valid,
    output quote_t     o_quote,
    input  logic       i_quote_ready
);

    book_cmd_t          cmd;
    logic               bid_cmd_valid;
    logic               ask_cmd_valid;
    logic               reject;
    logic               release_q;
    logic [STOCK_W-1:0] query_stock;
    logic               bid_done;
    logic               ask_done;
    book_status_e       bid_status;
    book_status_e       ask_status;
    side_best_t         bid_best;
    side_best_t         ask_best;

    order_dispatch dispatch_i (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_order_valid   (i_order_valid),
        .i_order         (i_order),
        .i_release       (release_q),
        .o_busy          (o_busy),
        .o_cmd           (cmd),
        .o_bid_cmd_valid (bid_cmd_valid),
        .o_ask_cmd_valid (ask_cmd_valid),
        .o_reject        (reject)
    );

    price_level_book #(.IS_ASK(1'b0)) bid_book_i (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_cmd         (cmd),
        .i_cmd_valid   (bid_cmd_valid),
        .i_query_stock (query_stock),
        .o_done        (bid_done),
        .o_status      (bid_status),
        .o_best        (bid_best)
    );

    price_level_book #(.IS_ASK(1'b1)) ask_book_i (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_cmd         (cmd),
        .i_cmd_valid   (ask_cmd_valid),
        .i_query_stock (query_stock),
        .o_done        (ask_done),
        .o_status      (ask_status),
        .o_best        (ask_best)
    );

    quote_merge merge_i (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_bid_done    (bid_done),
        .i_ask_done    (ask_done),
        .i_bid_status  (bid_status),
        .i_ask_status  (ask_status),
        .i_reject      (reject),
        .i_stock       (cmd.stock),
        .i_bid_best    (bid_best),
        .i_ask_best    (ask_best),
        .i_quote_ready (i_quote_ready),
        .o_query_stock (query_stock),
        .o_quote_valid (o_quote_valid),
        .o_quote       (o_quote),
        .o_release     (release_q)
    );

endmodule

//--- order_book/order_dispatch.sv
/* order dispatcher
   takes one order at a time and sends it to the bid or ask book */
`timescale 1ns/1ps

module order_dispatch import order_book_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_order_valid,
    input  order_msg_t i_order,
    input  logic       i_release,
    output logic       o_busy,
    output book_cmd_t  o_cmd,
    output logic       o_bid_cmd_valid,
    output logic       o_ask_cmd_valid,
    output logic       o_reject
);

    logic accept;
    logic book_op;
    logic any_cmd;

    // orders offered while busy are dropped
    assign accept = i_order_valid && !o_busy;
    assign book_op = (i_order.op == ADD) || (i_order.op == CANCEL);
    assign any_cmd = o_bid_cmd_valid || o_ask_cmd_valid || o_reject;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_busy <= 1'b0;
            o_bid_cmd_valid <= 1'b0;
            o_ask_cmd_valid <= 1'b0;
            o_reject <= 1'b0;
        end else begin
            o_bid_cmd_valid <= 1'b0;
            o_ask_cmd_valid <= 1'b0;
            o_reject <= 1'b0;
            if (accept) begin
                o_busy <= 1'b1;
                if (book_op) begin
                    o_bid_cmd_valid <= (i_order.side == BID);
                    o_ask_cmd_valid <= (i_order.side == ASK);
                end else begin
                    o_reject <= 1'b1;
                end
            end else if (i_release) begin
                o_busy <= 1'b0;
            end
        end
    end

    // command word stays put until the next accepted order,
    // both books and the quote merger read it while the order is in flight
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_cmd.op <= i_order.op;
            o_cmd.stock <= i_order.stock;
            o_cmd.entry.quantity <= i_order.quantity;
            o_cmd.entry.price <= i_order.price;
            o_cmd.entry.order_id <= i_order.order_id;
        end
    end

    // one order in flight, the next strobe waits for the quote release
    a_one_in_flight: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        any_cmd |=> (!any_cmd until i_release)
    );

endmodule

//--- order_book/price_level_book.sv
/* one side of the order book
   per-stock order lists with add, cancel by id and best-price rescan */
`timescale 1ns/1ps

module price_level_book import order_book_pkg::*; #(
    parameter bit IS_ASK = 1'b0
) (
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  book_cmd_t          i_cmd,
    input  logic               i_cmd_valid,
    input  logic [STOCK_W-1:0] i_query_stock,
    output logic               o_done,
    output book_status_e       o_status,
    output side_best_t         o_best
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEARCH,
        S_SHIFT,
        S_SCAN
    } book_state_e;

    book_state_e        state_q;
    book_entry_t        mem_q [NUM_STOCKS][BOOK_DEPTH];
    logic [SLOT_W-1:0]  cnt_q [NUM_STOCKS];
    side_best_t         best_q [NUM_STOCKS];
    logic [SLOT_W-1:0]  idx_q;
    logic [SLOT_W-1:0]  idx_nxt;
    logic [PRICE_W-1:0] acc_q;
    logic [PRICE_W-1:0] scan_best;
    logic [STOCK_W-1:0] stk;
    logic [SLOT_W-1:0]  cnt;
    logic               full;
    logic               better;
    book_entry_t        cur;

    // stock comes straight from the held command word
    assign stk = i_cmd.stock;
    assign cnt = cnt_q[stk];
    assign full = (cnt == SLOT_W'(BOOK_DEPTH));
    assign idx_nxt = idx_q + 1'b1;
    // BOOK_DEPTH is a power of two, low bits address the slot
    assign cur = mem_q[stk][idx_q[SLOT_W-2:0]];
    assign o_best = best_q[i_query_stock];

    always_comb begin
        better = IS_ASK ? (cur.price < acc_q) : (cur.price > acc_q);
        scan_best = (idx_q == '0 || better) ? cur.price : acc_q;
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q <= S_IDLE;
            o_done <= 1'b0;
            for (int s = 0; s < NUM_STOCKS; s++) begin
                cnt_q[s] <= '0;
                best_q[s] <= '0;
            end
        end else begin
            o_done <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    idx_q <= '0;
                    if (i_cmd_valid && i_cmd.op == ADD) begin
                        if (full) begin
                            o_status <= ST_FULL;
                            o_done <= 1'b1;
                        end else begin
                            cnt_q[stk] <= cnt + 1'b1;
                            state_q <= S_SCAN;
                        end
                    end else if (i_cmd_valid) begin
                        if (cnt == '0) begin
                            o_status <= ST_NOT_FOUND;
                            o_done <= 1'b1;
                        end else begin
                            state_q <= S_SEARCH;
                        end
                    end
                end
                S_SEARCH: begin
                    if (cur.order_id == i_cmd.entry.order_id) begin
                        cnt_q[stk] <= cnt - 1'b1;
                        state_q <= S_SHIFT;
                    end else if (idx_q == cnt - 1'b1) begin
                        o_status <= ST_NOT_FOUND;
                        o_done <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        idx_q <= idx_nxt;
                    end
                end
                S_SHIFT: begin
                    // cnt already holds the reduced count here
                    if (idx_q == cnt) begin
                        idx_q <= '0;
                        if (cnt == '0) begin
                            best_q[stk] <= '0;
                            o_status <= ST_OK;
                            o_done <= 1'b1;
                            state_q <= S_IDLE;
                        end else begin
                            state_q <= S_SCAN;
                        end
                    end else begin
                        idx_q <= idx_nxt;
                    end
                end
                S_SCAN: begin
                    acc_q <= scan_best;
                    if (idx_q == cnt - 1'b1) begin
                        best_q[stk].has_best <= 1'b1;
                        best_q[stk].price <= scan_best;
                        o_status <= ST_OK;
                        o_done <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        idx_q <= idx_nxt;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // entry storage, append at the count or pull the next entry up
    always_ff @(posedge i_clk) begin
        if (state_q == S_IDLE && i_cmd_valid && i_cmd.op == ADD && !full) begin
            mem_q[stk][cnt[SLOT_W-2:0]] <= i_cmd.entry;
        end else if (state_q == S_SHIFT && idx_q != cnt) begin
            mem_q[stk][idx_q[SLOT_W-2:0]] <= mem_q[stk][idx_nxt[SLOT_W-2:0]];
        end
    end

    a_cnt_range: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        cnt <= SLOT_W'(BOOK_DEPTH)
    );

    // dispatcher holds off new commands until the quote is released
    a_no_cmd_on_done: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        !(o_done && i_cmd_valid)
    );

endmodule

//--- order_book/quote_merge.sv
/* quote merger
   joins both side results into one quote held under a ready handshake */
`timescale 1ns/1ps

module quote_merge import order_book_pkg::*; (
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  logic               i_bid_done,
    input  logic               i_ask_done,
    input  book_status_e       i_bid_status,
    input  book_status_e       i_ask_status,
    input  logic               i_reject,
    input  logic [STOCK_W-1:0] i_stock,
    input  side_best_t         i_bid_best,
    input  side_best_t         i_ask_best,
    input  logic               i_quote_ready,
    output logic [STOCK_W-1:0] o_query_stock,
    output logic               o_quote_valid,
    output quote_t             o_quote,
    output logic               o_release
);

    logic         finish;
    logic         pend_q;
    book_status_e status_q;

    assign finish = i_bid_done || i_ask_done || i_reject;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            pend_q <= 1'b0;
            o_quote_valid <= 1'b0;
            o_release <= 1'b0;
            o_query_stock <= '0;
        end else begin
            pend_q <= finish;
            o_release <= 1'b0;
            if (finish) begin
                o_query_stock <= i_stock;
            end
            if (pend_q) begin
                o_quote_valid <= 1'b1;
            end else if (o_quote_valid && i_quote_ready) begin
                o_quote_valid <= 1'b0;
                o_release <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (finish) begin
            status_q <= i_reject ? ST_BAD_OP : (i_bid_done ? i_bid_status : i_ask_status);
        end
        // books answer for the query stock one cycle after it is set
        if (pend_q) begin
            o_quote.stock <= o_query_stock;
            o_quote.status <= status_q;
            o_quote.bid <= i_bid_best;
            o_quote.ask <= i_ask_best;
            o_quote.crossed <= i_bid_best.has_best && i_ask_best.has_best &&
                               (i_bid_best.price >= i_ask_best.price);
        end
    end

    a_quote_hold: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (o_quote_valid && !i_quote_ready) |=> (o_quote_valid && $stable(o_quote))
    );

endmodule

//--- sim/order_book_tb.sv
/* order book testbench
   reference model per stock and side, random prices and quote checks */
`timescale 1ns/1ps

module order_book_tb import order_book_pkg::*; ();

    // 60 orders at the worst cancel latency plus handshake, then reset
    localparam int TIMEOUT_CYCLES = 60 * (3 * BOOK_DEPTH + 10) + 3;

    logic       i_clk;
    logic       i_reset_n;
    logic       i_order_valid;
    order_msg_t i_order;
    logic       o_busy;
    logic       o_quote_valid;
    quote_t     o_quote;
    logic       i_quote_ready;

    integer seed = 32'h2fa1_462b;
    int     cycles = 0;
    int     err_count = 0;
    int     test_err = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    string  test_name;

    // resting orders in arrival order, indexed by side then stock
    book_entry_t book_q [2][NUM_STOCKS][$];

    order_book dut_i (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_order_valid (i_order_valid),
        .i_order       (i_order),
        .o_busy        (o_busy),
        .o_quote_valid (o_quote_valid),
        .o_quote       (o_quote),
        .i_quote_ready (i_quote_ready)
    );

    initial i_clk = 1'b0;
    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    a_quote_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_quote_valid && !i_quote_ready) |=> (o_quote_valid && $stable(o_quote)))
    else begin
        $display("quote changed or dropped while waiting for ready");
        err_count++;
    end

    a_busy_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_quote_valid |-> o_busy)
    else begin
        $display("busy went low while a quote was pending");
        err_count++;
    end

    a_quote_taken: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_quote_valid && i_quote_ready) |=> !o_quote_valid)
    else begin
        $display("quote stayed valid after it was taken");
        err_count++;
    end

    function automatic side_best_t model_best(input int side, input int stock);
        side_best_t b;
        logic [PRICE_W-1:0] p;
        b = '0;
        for (int i = 0; i < book_q[side][stock].size(); i++) begin
            p = book_q[side][stock][i].price;
            // bids keep the highest price, asks the lowest
            if (!b.has_best || (side == 1 ? p < b.price : p > b.price)) begin
                b.has_best = 1'b1;
                b.price = p;
            end
        end
        return b;
    endfunction

    function automatic quote_t model_apply(input order_msg_t msg);
        quote_t q;
        book_entry_t e;
        int s;
        int k;
        int hit;
        s = int'(msg.side);
        k = int'(msg.stock);
        e.quantity = msg.quantity;
        e.price = msg.price;
        e.order_id = msg.order_id;
        hit = -1;
        q = '0;
        q.stock = msg.stock;
        if (msg.op == ADD) begin
            if (book_q[s][k].size() == BOOK_DEPTH) begin
                q.status = ST_FULL;
            end else begin
                book_q[s][k].push_back(e);
                q.status = ST_OK;
            end
        end else if (msg.op == CANCEL) begin
            for (int i = 0; i < book_q[s][k].size(); i++) begin
                if (hit < 0 && book_q[s][k][i].order_id == msg.order_id) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                q.status = ST_NOT_FOUND;
            end else begin
                book_q[s][k].delete(hit);
                q.status = ST_OK;
            end
        end else begin
            q.status = ST_BAD_OP;
        end
        q.bid = model_best(0, k);
        q.ask = model_best(1, k);
        q.crossed = q.bid.has_best && q.ask.has_best && (q.bid.price >= q.ask.price);
        return q;
    endfunction

    function automatic logic [PRICE_W-1:0] rand_price(input logic [PRICE_W-1:0] base);
        return base + (32'($random(seed)) & 32'h0000_00ff);
    endfunction

    function automatic logic [ID_W-1:0] new_id();
        return 32'($random(seed));
    endfunction

    // an id that no resting order on this side and stock carries
    function automatic logic [ID_W-1:0] unknown_id(input int side, input int stock);
        logic [ID_W-1:0] id;
        logic clash;
        do begin
            id = new_id();
            clash = 1'b0;
            for (int i = 0; i < book_q[side][stock].size(); i++) begin
                if (book_q[side][stock][i].order_id == id) begin
                    clash = 1'b1;
                end
            end
        end while (clash);
        return id;
    endfunction

    function automatic logic [ID_W-1:0] best_id(input int side, input int stock);
        side_best_t b;
        b = model_best(side, stock);
        for (int i = 0; i < book_q[side][stock].size(); i++) begin
            if (book_q[side][stock][i].price == b.price) begin
                return book_q[side][stock][i].order_id;
            end
        end
        return '0;
    endfunction

    function automatic order_msg_t make_order(input order_op_e op, input side_e side,
            input int stock, input logic [PRICE_W-1:0] price, input logic [ID_W-1:0] id);
        order_msg_t m;
        m.op = op;
        m.side = side;
        m.stock = STOCK_W'(stock);
        m.quantity = QTY_W'($random(seed));
        m.price = price;
        m.order_id = id;
        return m;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic send_order(input order_msg_t msg);
        @(posedge i_clk);
        i_order_valid <= 1'b1;
        i_order <= msg;
        @(posedge i_clk);
        i_order_valid <= 1'b0;
    endtask

    task automatic take_quote(input int hold, output quote_t q);
        do @(negedge i_clk); while (!o_quote_valid);
        repeat (hold) @(negedge i_clk);
        q = o_quote;
        @(posedge i_clk);
        i_quote_ready <= 1'b1;
        @(posedge i_clk);
        i_quote_ready <= 1'b0;
    endtask

    // poke offers a high bid while busy, which the DUT must drop
    task automatic run_order(input order_msg_t msg, input int hold, input logic poke);
        quote_t exp;
        quote_t got;
        do @(negedge i_clk); while (o_busy);
        exp = model_apply(msg);
        send_order(msg);
        if (poke) begin
            @(negedge i_clk);
            check_field("o_busy", 32'(o_busy), 32'd1);
            send_order(make_order(ADD, BID, int'(msg.stock), 32'hffff_0000, new_id()));
        end
        take_quote(hold, got);
        check_field("o_quote.stock", 32'(got.stock), 32'(exp.stock));
        check_field("o_quote.status", 32'(got.status), 32'(exp.status));
        check_field("o_quote.bid.has_best", 32'(got.bid.has_best), 32'(exp.bid.has_best));
        check_field("o_quote.bid.price", got.bid.price, exp.bid.price);
        check_field("o_quote.ask.has_best", 32'(got.ask.has_best), 32'(exp.ask.has_best));
        check_field("o_quote.ask.price", got.ask.price, exp.ask.price);
        check_field("o_quote.crossed", 32'(got.crossed), 32'(exp.crossed));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count != test_err) begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, err_count - test_err);
        end else begin
            $display("test %s ok", test_name);
        end
    endtask

    initial begin
        i_reset_n = 1'b0;
        i_order_valid = 1'b0;
        i_order = '0;
        i_quote_ready = 1'b0;
        repeat (3) @(posedge i_clk);
        i_reset_n <= 1'b1;

        start_test("reset");
        @(negedge i_clk);
        check_field("o_busy", 32'(o_busy), 32'd0);
        check_field("o_quote_valid", 32'(o_quote_valid), 32'd0);
        run_order(make_order(ADD, BID, 0, rand_price(32'd1000), new_id()), 0, 1'b0);
        end_test();

        start_test("adds on both sides");
        for (int i = 0; i < 4; i++) begin
            run_order(make_order(ADD, BID, 1, rand_price(32'd1000), new_id()), 0, 1'b0);
            run_order(make_order(ADD, ASK, 1, rand_price(32'd1100), new_id()), 0, 1'b0);
        end
        run_order(make_order(ADD, BID, 3, rand_price(32'd1000), new_id()), 0, 1'b0);
        run_order(make_order(ADD, ASK, 3, rand_price(32'd1100), new_id()), 0, 1'b0);
        // stock 0 must still show only its first bid
        run_order(make_order(CANCEL, ASK, 0, 32'd0, unknown_id(1, 0)), 0, 1'b0);
        end_test();

        start_test("cancel");
        run_order(make_order(CANCEL, BID, 1, 32'd0, best_id(0, 1)), 0, 1'b0);
        run_order(make_order(CANCEL, ASK, 1, 32'd0, book_q[1][1][2].order_id), 0, 1'b0);
        run_order(make_order(CANCEL, BID, 1, 32'd0, unknown_id(0, 1)), 0, 1'b0);
        run_order(make_order(CANCEL, BID, 3, 32'd0, book_q[0][3][0].order_id), 0, 1'b0);
        run_order(make_order(CANCEL, ASK, 3, 32'd0, book_q[1][3][0].order_id), 0, 1'b0);
        end_test();

        start_test("full book");
        for (int i = 0; i <= BOOK_DEPTH; i++) begin
            run_order(make_order(ADD, ASK, 2, rand_price(32'd1100), new_id()), 0, 1'b0);
        end
        run_order(make_order(ADD, BID, 2, rand_price(32'd1000), new_id()), 0, 1'b0);
        run_order(make_order(ADD, ASK, 0, rand_price(32'd1100), new_id()), 0, 1'b0);
        end_test();

        start_test("handshake and bad op");
        for (int i = 0; i < 6; i++) begin
            run_order(make_order(ADD, side_e'(i % 2), 3, rand_price(32'd1050), new_id()),
                      int'($unsigned($random(seed)) % 6), 1'b1);
        end
        run_order(make_order(EXECUTE, BID, 1, rand_price(32'd1000), new_id()), 2, 1'b0);
        run_order(make_order(CANCEL, BID, 1, 32'd0, unknown_id(0, 1)), 0, 1'b0);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
